/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = noc_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/noc_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module noc_clock
(
    output logic clk_o,
    output logic reset_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o; // 100 ns period
    end

    initial
    begin
        reset_o = 1'b1;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

/* bench/noc_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module noc_tb import noc_pkg::*;
();

    logic              clk;
    logic              reset;
    logic              cfg_req;
    cfg_t              cfg;
    logic              cfg_ack;
    logic              start;
    logic              deliv_req;
    delivery_t         deliv;
    logic              deliv_ack;
    logic              done;
    logic [STEP_W-1:0] steps;

    logic [31:0]          lfsr_state;
    int                   errors;
    int                   sent;
    int                   delivered;
    int                   max_hops;
    logic                 to_ring_tbl [NUM_NODES][NUM_NODES];
    logic [PAYLOAD_W-1:0] sent_q [NUM_NODES*NUM_NODES][$]; // per src/dst pair in send order

    noc_clock i_noc_clock
    (
        .clk_o   (clk),
        .reset_o (reset)
    );

    noc_top i_noc_top
    (
        .clk         (clk),
        .reset       (reset),
        .cfg_req_i   (cfg_req),
        .cfg_i       (cfg),
        .cfg_ack_o   (cfg_ack),
        .start_i     (start),
        .deliv_req_o (deliv_req),
        .deliv_o     (deliv),
        .deliv_ack_i (deliv_ack),
        .done_o      (done),
        .steps_o     (steps)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // walk the ring from src until an entry says local
    function automatic int deliver_node(input int src, input int dst);
        int node;
        node = src;
        for (int k = 0; k < NUM_NODES; k++)
        begin
            if (!to_ring_tbl[node][dst])
                return node;
            node = (node + 1) % NUM_NODES;
        end
        return -1;
    endfunction

    function automatic cfg_t route_word(input int node, input int dst, input logic to_ring);
        cfg_t w;
        w = '0;
        w.kind    = CFG_ROUTE;
        w.node    = NODE_W'(node);
        w.dst     = NODE_W'(dst);
        w.to_ring = to_ring;
        return w;
    endfunction

    function automatic cfg_t packet_word(input int node, input int dst,
                                         input logic [PAYLOAD_W-1:0] payload);
        cfg_t w;
        w = '0;
        w.kind    = CFG_PACKET;
        w.node    = NODE_W'(node);
        w.dst     = NODE_W'(dst);
        w.payload = payload;
        return w;
    endfunction

    task automatic fail_check(input string msg);
        errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("errors: %0d, sent: %0d, delivered: %0d", errors, sent, delivered);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic send_cfg(input cfg_t w);
        int waited;
        cfg     = w;
        cfg_req = 1'b1;
        waited  = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end while (!cfg_ack && waited < 50);
        if (!cfg_ack)
        begin
            abort_run("timeout: cfg_ack_o never rose for a config word");
        end
        else
        begin
            cfg_req = 1'b0;
            waited  = 0;
            do
            begin
                @(negedge clk);
                waited++;
            end while (cfg_ack && waited < 50);
            if (cfg_ack)
                abort_run("timeout: cfg_ack_o stayed high after the request fell");
        end
    endtask

    task automatic check_delivery(input delivery_t d);
        int pair;
        int exp_node;
        int hops;
        pair     = int'(d.src) * NUM_NODES + int'(d.dst);
        exp_node = deliver_node(int'(d.src), int'(d.dst));
        a_node: assert (int'(d.node) == exp_node)
            else fail_check($sformatf("flit %0d->%0d delivered at node %0d, expected %0d",
                                      d.src, d.dst, d.node, exp_node));
        a_known: assert (sent_q[pair].size() > 0)
            else fail_check($sformatf("flit %0d->%0d payload %0h was never sent or came twice",
                                      d.src, d.dst, d.payload));
        if (sent_q[pair].size() > 0)
        begin
            a_order: assert (sent_q[pair][0] == d.payload)
                else fail_check($sformatf("flit %0d->%0d payload %0h, expected %0h",
                                          d.src, d.dst, d.payload, sent_q[pair][0]));
            void'(sent_q[pair].pop_front());
        end
        hops = (int'(d.node) - int'(d.src) + NUM_NODES) % NUM_NODES;
        if (hops > max_hops)
            max_hops = hops;
        delivered++;
    endtask

    a_cfg_ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(cfg_req) |=> $rose(cfg_ack)) else fail_check("cfg ack did not follow request");
    a_cfg_ack_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(cfg_req) |=> $fell(cfg_ack)) else fail_check("cfg ack did not drop after request");
    a_cfg_ack_high: assert property (@(posedge clk) disable iff (reset)
        $rose(cfg_ack) |-> $past(cfg_req)) else fail_check("cfg ack rose without request");
    a_cfg_ack_low: assert property (@(posedge clk) disable iff (reset)
        $fell(cfg_ack) |-> $past(!cfg_req)) else fail_check("cfg ack fell with request high");
    a_deliv_stable: assert property (@(posedge clk) disable iff (reset)
        $past(deliv_req) && deliv_req |-> $stable(deliv))
        else fail_check("deliv_o changed while deliv_req_o high");
    a_deliv_req_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(deliv_req) |-> $past(!deliv_ack)) else fail_check("deliv_req_o rose before ack low");
    a_deliv_req_fall: assert property (@(posedge clk) disable iff (reset)
        deliv_req && deliv_ack |=> !deliv_req) else fail_check("deliv_req_o held after ack");
    a_done_hold: assert property (@(posedge clk) disable iff (reset)
        done |=> done) else fail_check("done_o dropped");
    a_steps_hold: assert property (@(posedge clk) disable iff (reset)
        done |=> $stable(steps)) else fail_check("steps_o changed after done_o");

    // delivery consumer with random stalls
    initial
    begin : consumer
        int stall;
        int waited;
        deliv_ack = 1'b0;
        forever
        begin
            @(negedge clk);
            if (deliv_req && !deliv_ack)
            begin
                if (delivered == 0)
                    stall = 60; // long first stall fills the delivery queue
                else if (take_bits(2) == 0)
                    stall = 8 + int'(take_bits(3));
                else
                    stall = int'(take_bits(1));
                repeat (stall) @(negedge clk);
                check_delivery(deliv);
                deliv_ack = 1'b1;
                waited    = 0;
                do
                begin
                    @(negedge clk);
                    waited++;
                end while (deliv_req && waited < 20);
                if (deliv_req)
                    abort_run("timeout: deliv_req_o stayed high after the ack");
                else
                    deliv_ack = 1'b0;
            end
        end
    end

    initial
    begin : stimulus
        int                   waited;
        int                   src;
        int                   dst;
        int                   per_node [NUM_NODES];
        logic [PAYLOAD_W-1:0] payload;
        cfg_req    = 1'b0;
        cfg        = '0;
        start      = 1'b0;
        lfsr_state = 32'h9d0f70f7;
        errors     = 0;
        sent       = 0;
        delivered  = 0;
        max_hops   = 0;
        per_node   = '{default: 0};
        waited     = 0;
        while (reset !== 1'b0 && waited < 20)
        begin
            @(negedge clk);
            waited++;
        end
        if (reset !== 1'b0)
            abort_run("timeout: reset was never released");
        @(negedge clk);
        a_reset_vals: assert (!cfg_ack && !deliv_req && !done && steps == '0)
            else fail_check("outputs not at their reset values");

        // ring for every foreign dst but node 2 keeps dst 0 local
        for (int n = 0; n < NUM_NODES; n++)
        begin
            for (int d = 0; d < NUM_NODES; d++)
            begin
                to_ring_tbl[n][d] = (n != d) && !(n == 2 && d == 0);
                send_cfg(route_word(n, d, to_ring_tbl[n][d]));
            end
        end

        for (int k = 0; k < 28; k++)
        begin
            src = int'(take_bits(2));
            while (per_node[src] == QUEUE_DEPTH)
                src = (src + 1) % NUM_NODES;
            dst     = int'(take_bits(2));
            payload = PAYLOAD_W'(take_bits(8));
            send_cfg(packet_word(src, dst, payload));
            sent_q[src * NUM_NODES + dst].push_back(payload);
            per_node[src]++;
            sent++;
        end

        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        waited = 0;
        while (!done && waited < 20000)
        begin
            @(negedge clk);
            waited++;
        end
        if (!done)
        begin
            abort_run($sformatf("timeout: done_o never rose, %0d of %0d packets delivered",
                                delivered, sent));
        end
        else
        begin
            a_all_acked: assert (delivered == sent && !deliv_req)
                else fail_check("done_o rose before the last delivery was acknowledged");
            a_step_bound: assert (int'(steps) >= max_hops + 1)
                else fail_check($sformatf("steps_o %0d too small for %0d hops", steps, max_hops));
            repeat (10) @(negedge clk);
            for (int p = 0; p < NUM_NODES * NUM_NODES; p++)
            begin
                a_none_left: assert (sent_q[p].size() == 0)
                    else fail_check($sformatf("%0d packets %0d->%0d never delivered",
                                              sent_q[p].size(), p / NUM_NODES, p % NUM_NODES));
            end

            $display("errors: %0d, sent: %0d, delivered: %0d, steps: %0d",
                     errors, sent, delivered, steps);
            if (errors == 0)
                $display("Test OK");
            else
                $display("Test FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* files.f */
src/noc_pkg.sv
src/noc_fifo.sv
src/noc_config_regs.sv
src/noc_router.sv
src/noc_sequencer.sv
src/noc_top.sv
bench/noc_clock.sv
bench/noc_tb.sv

/* src/noc_config_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module noc_config_regs import noc_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 cfg_req_i,
    input  cfg_t                                 cfg_i,
    output logic                                 cfg_ack_o,
    input  logic                                 idle_i,
    output logic [NUM_NODES-1:0][NUM_NODES-1:0]  route_row_o,
    output logic [NUM_NODES-1:0]                 push_o,
    output flit_t                                push_flit_o,
    input  logic [NUM_NODES-1:0]                 queue_full_i
);

    logic is_packet;
    logic accept;

    assign is_packet = (cfg_i.kind == CFG_PACKET);

    // a packet word for a full queue is held off until space frees up
    assign accept = cfg_req_i && !cfg_ack_o && idle_i &&
                    !(is_packet && queue_full_i[cfg_i.node]);

    always_comb
    begin
        push_o = '0;
        if (accept && is_packet)
            push_o[cfg_i.node] = 1'b1; // one push per accepted word
    end

    assign push_flit_o = '{valid:   1'b1,
                           src:     cfg_i.node,
                           dst:     cfg_i.dst,
                           payload: cfg_i.payload};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg_ack_o   <= 1'b0;
            route_row_o <= '0; // all local
        end
        else
        begin
            if (accept)
            begin
                cfg_ack_o <= 1'b1;
                if (!is_packet)
                    route_row_o[cfg_i.node][cfg_i.dst] <= cfg_i.to_ring;
            end
            else if (cfg_ack_o && !cfg_req_i)
            begin
                cfg_ack_o <= 1'b0;
            end
        end
    end

    // config words belong before start, never during a run
    a_cfg_only_idle: assert property (@(posedge clk) disable iff (reset)
        $rose(cfg_req_i) |-> idle_i);

endmodule

`default_nettype wire

/* src/noc_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module noc_fifo import noc_pkg::*;
#(
    parameter type payload_t = flit_t,
    parameter int  DEPTH     = QUEUE_DEPTH
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] wr_ptr;
    logic [CW-1:0] count;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign data_o  = mem[rd_ptr]; // head
    assign empty_o = (count == '0);
    assign full_o  = (count == CW'(DEPTH));

    always_ff @(posedge clk)
    begin
        if (push_i)
            mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop_i)
                rd_ptr <= next_ptr(rd_ptr);
            if (push_i && !pop_i)
                count <= count + 1'b1;
            else if (pop_i && !push_i)
                count <= count - 1'b1;
        end
    end

    a_no_overflow:  assert property (@(posedge clk) disable iff (reset) push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* src/noc_pkg.sv */
`default_nettype none

package noc_pkg;

    localparam int NUM_NODES   = 4;
    localparam int NODE_W      = 2;
    localparam int PAYLOAD_W   = 8;
    localparam int QUEUE_DEPTH = 8;
    localparam int STEP_W      = 16;

    // one flit is one whole packet
    typedef struct packed
    {
        logic                 valid;
        logic [NODE_W-1:0]    src;
        logic [NODE_W-1:0]    dst;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    typedef enum logic
    {
        CFG_ROUTE  = 1'b0,
        CFG_PACKET = 1'b1
    } cfg_kind_t;

    // route word uses node, dst, to_ring
    // packet word uses node, dst, payload
    typedef struct packed
    {
        cfg_kind_t            kind;
        logic [NODE_W-1:0]    node;
        logic [NODE_W-1:0]    dst;
        logic                 to_ring;
        logic [PAYLOAD_W-1:0] payload;
    } cfg_t;

    typedef struct packed
    {
        logic [NODE_W-1:0]    node; // router that delivered it
        logic [NODE_W-1:0]    src;
        logic [NODE_W-1:0]    dst;
        logic [PAYLOAD_W-1:0] payload;
    } delivery_t;

    typedef enum logic [2:0]
    {
        IDLE    = 3'd0,
        STEP    = 3'd1,
        COLLECT = 3'd2,
        CHECK   = 3'd3,
        DONE    = 3'd4
    } seq_phase_t;

endpackage

`default_nettype wire

/* src/noc_router.sv */
`timescale 1ns/1ns
`default_nettype none

module noc_router import noc_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 step_i,
    input  flit_t                link_i,
    input  flit_t                inject_i,
    input  logic [NUM_NODES-1:0] route_row_i,
    output logic                 pop_o,
    output flit_t                link_o,
    output flit_t                deliv_o,
    input  logic                 clear_i
);

    flit_t link_q;
    flit_t deliv_q;
    flit_t cand;
    logic  to_ring;

    // ring traffic has priority over injection
    always_comb
    begin
        cand    = link_i.valid ? link_i : inject_i;
        to_ring = route_row_i[cand.dst];
    end

    assign pop_o   = step_i && !link_i.valid && inject_i.valid;
    assign link_o  = link_q;
    assign deliv_o = deliv_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            link_q  <= '0;
            deliv_q <= '0;
        end
        else
        begin
            if (step_i)
                link_q <= (cand.valid && to_ring) ? cand : '0;

            if (step_i && cand.valid && !to_ring)
                deliv_q <= cand;
            else if (clear_i)
                deliv_q.valid <= 1'b0; // taken by the collect walk
        end
    end

    // the collect walk must empty this register before the next step
    a_deliv_drained: assert property (@(posedge clk) disable iff (reset)
        step_i |-> !deliv_q.valid);

endmodule

`default_nettype wire

/* src/noc_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module noc_sequencer import noc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_i,
    output logic                  step_o,
    input  flit_t [NUM_NODES-1:0] deliv_i,
    output logic  [NUM_NODES-1:0] clear_o,
    output logic                  dq_push_o,
    output delivery_t             dq_data_o,
    input  logic                  dq_full_i,
    input  logic                  dq_empty_i,
    input  logic  [NUM_NODES-1:0] queues_empty_i,
    input  logic  [NUM_NODES-1:0] links_busy_i,
    output logic                  idle_o,
    output logic                  done_o,
    output logic  [STEP_W-1:0]    steps_o
);

    seq_phase_t        phase;
    logic [NODE_W-1:0] visit;
    logic [STEP_W-1:0] step_cnt;
    flit_t             cur;
    logic              visit_done;
    logic              last_visit;
    logic              any_deliv;
    logic              drained;

    assign cur        = deliv_i[visit];
    assign last_visit = (visit == NODE_W'(NUM_NODES - 1));

    // collect one node per cycle, stall while the queue is full
    always_comb
    begin
        visit_done = 1'b0;
        dq_push_o  = 1'b0;
        clear_o    = '0;
        if (phase == COLLECT)
        begin
            if (!cur.valid)
            begin
                visit_done = 1'b1;
            end
            else if (!dq_full_i)
            begin
                dq_push_o      = 1'b1;
                clear_o[visit] = 1'b1;
                visit_done     = 1'b1;
            end
        end
    end

    assign dq_data_o = '{node:    visit,
                         src:     cur.src,
                         dst:     cur.dst,
                         payload: cur.payload};

    always_comb
    begin
        any_deliv = 1'b0;
        for (int n = 0; n < NUM_NODES; n++)
            any_deliv = any_deliv | deliv_i[n].valid;
    end

    assign drained = (&queues_empty_i) && !(|links_busy_i) && !any_deliv && dq_empty_i;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase    <= IDLE;
            visit    <= '0;
            step_cnt <= '0;
        end
        else
        begin
            case (phase)
                IDLE:
                begin
                    if (start_i)
                        phase <= STEP;
                end
                STEP:
                begin
                    phase    <= COLLECT;
                    visit    <= '0;
                    step_cnt <= step_cnt + 1'b1;
                end
                COLLECT:
                begin
                    if (visit_done)
                    begin
                        if (last_visit)
                            phase <= CHECK;
                        else
                            visit <= visit + 1'b1;
                    end
                end
                CHECK:
                begin
                    phase <= drained ? DONE : STEP;
                end
                DONE:
                begin
                    phase <= DONE; // held until reset
                end
                default:
                begin
                    phase <= IDLE;
                end
            endcase
        end
    end

    assign step_o  = (phase == STEP);
    assign idle_o  = (phase == IDLE);
    assign done_o  = (phase == DONE);
    assign steps_o = step_cnt;

endmodule

`default_nettype wire

/* src/noc_top.sv */
`timescale 1ns/1ns
`default_nettype none

module noc_top import noc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              cfg_req_i,
    input  cfg_t              cfg_i,
    output logic              cfg_ack_o,
    input  logic              start_i,
    output logic              deliv_req_o,
    output delivery_t         deliv_o,
    input  logic              deliv_ack_i,
    output logic              done_o,
    output logic [STEP_W-1:0] steps_o
);

    logic [NUM_NODES-1:0][NUM_NODES-1:0] route_row;
    logic [NUM_NODES-1:0] push;
    logic [NUM_NODES-1:0] q_pop;
    logic [NUM_NODES-1:0] q_empty;
    logic [NUM_NODES-1:0] q_full;
    logic [NUM_NODES-1:0] clear;
    logic [NUM_NODES-1:0] links_busy;
    flit_t                push_flit;
    flit_t [NUM_NODES-1:0] q_head;
    flit_t [NUM_NODES-1:0] inject;
    flit_t [NUM_NODES-1:0] link;
    flit_t [NUM_NODES-1:0] deliv;

    logic      step;
    logic      idle;
    logic      dq_push;
    logic      dq_pop;
    logic      dq_full;
    logic      dq_empty;
    delivery_t dq_data;
    logic      wait_ack_low;

    noc_config_regs i_config_regs
    (
        .clk          (clk),
        .reset        (reset),
        .cfg_req_i    (cfg_req_i),
        .cfg_i        (cfg_i),
        .cfg_ack_o    (cfg_ack_o),
        .idle_i       (idle),
        .route_row_o  (route_row),
        .push_o       (push),
        .push_flit_o  (push_flit),
        .queue_full_i (q_full)
    );

    for (genvar n = 0; n < NUM_NODES; n++)
    begin : g_node
        noc_fifo #(.payload_t(flit_t), .DEPTH(QUEUE_DEPTH)) i_inject_q
        (
            .clk     (clk),
            .reset   (reset),
            .push_i  (push[n]),
            .data_i  (push_flit),
            .pop_i   (q_pop[n]),
            .data_o  (q_head[n]),
            .empty_o (q_empty[n]),
            .full_o  (q_full[n])
        );

        // stale head is masked when the queue is empty
        assign inject[n] = '{valid:   !q_empty[n],
                             src:     q_head[n].src,
                             dst:     q_head[n].dst,
                             payload: q_head[n].payload};

        noc_router i_router
        (
            .clk         (clk),
            .reset       (reset),
            .step_i      (step),
            .link_i      (link[(n + NUM_NODES - 1) % NUM_NODES]), // upstream neighbour
            .inject_i    (inject[n]),
            .route_row_i (route_row[n]),
            .pop_o       (q_pop[n]),
            .link_o      (link[n]),
            .deliv_o     (deliv[n]),
            .clear_i     (clear[n])
        );

        assign links_busy[n] = link[n].valid;
    end

    noc_sequencer i_sequencer
    (
        .clk            (clk),
        .reset          (reset),
        .start_i        (start_i),
        .step_o         (step),
        .deliv_i        (deliv),
        .clear_o        (clear),
        .dq_push_o      (dq_push),
        .dq_data_o      (dq_data),
        .dq_full_i      (dq_full),
        .dq_empty_i     (dq_empty),
        .queues_empty_i (q_empty),
        .links_busy_i   (links_busy),
        .idle_o         (idle),
        .done_o         (done_o),
        .steps_o        (steps_o)
    );

    noc_fifo #(.payload_t(delivery_t), .DEPTH(QUEUE_DEPTH)) i_deliv_q
    (
        .clk     (clk),
        .reset   (reset),
        .push_i  (dq_push),
        .data_i  (dq_data),
        .pop_i   (dq_pop),
        .data_o  (deliv_o),
        .empty_o (dq_empty),
        .full_o  (dq_full)
    );

    assign dq_pop = deliv_req_o && deliv_ack_i;

    // four-phase delivery handshake
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            deliv_req_o  <= 1'b0;
            wait_ack_low <= 1'b0;
        end
        else if (dq_pop)
        begin
            deliv_req_o  <= 1'b0;
            wait_ack_low <= 1'b1;
        end
        else if (wait_ack_low)
        begin
            if (!deliv_ack_i)
                wait_ack_low <= 1'b0;
        end
        else if (!deliv_req_o && !dq_empty)
        begin
            deliv_req_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire
